// ==== rtl/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Opcodes live in instruction bits 15:12
// ALU group occupies the lower half of the map
`define OP_ADD   4'b0000
`define OP_ADDZ  4'b0001
`define OP_SUB   4'b0010
`define OP_AND   4'b0011
`define OP_NOR   4'b0100
`define OP_SLL   4'b0101
`define OP_SRL   4'b0110
`define OP_SRA   4'b0111

// Memory and byte load group
`define OP_LW    4'b1000
`define OP_SW    4'b1001
`define OP_LHB   4'b1010
`define OP_LLB   4'b1011

// Control flow group, HLT sits at the very top of the map
`define OP_B     4'b1100
`define OP_JAL   4'b1101
`define OP_JR    4'b1110
`define OP_HLT   4'b1111

// Branch conditions carried in bits 11:9 of a B instruction
`define COND_NEQ    3'b000
`define COND_EQ     3'b001
`define COND_GT     3'b010
`define COND_LT     3'b011
`define COND_GTE    3'b100
`define COND_LTE    3'b101
`define COND_OVFL   3'b110
`define COND_UNCOND 3'b111

// Register file geometry and the JAL return register
`define NUM_REGS 16
`define LINK_REG 4'd15

`endif

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

  // Register format used by the ALU group, LW, SW and JR
  typedef struct packed {
    logic [3:0] opcode;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
  } r_fmt_t;

  // Immediate format used by LHB and LLB
  // JAL reads rd and imm8 together as its 12-bit offset
  typedef struct packed {
    logic [3:0] opcode;
    logic [3:0] rd;
    logic [7:0] imm8;
  } i_fmt_t;

  // Branch format with a 3-bit condition and a 9-bit word offset
  typedef struct packed {
    logic [3:0] opcode;
    logic [2:0] cond;
    logic [8:0] imm9;
  } b_fmt_t;

  // One instruction word seen through all three formats
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
  } instr_t;

  // Condition flags held in the ALU
  typedef struct packed {
    logic zr;
    logic ne;
    logic ov;
  } flags_t;

  // ALU functions, encoded to match opcode bits 14:12 of the ALU group
  // LHB takes the slot that ADDZ frees up, since ADDZ runs as ADD
  typedef enum logic [2:0] {
    FUNC_ADD = 3'b000,
    FUNC_LHB = 3'b001,
    FUNC_SUB = 3'b010,
    FUNC_AND = 3'b011,
    FUNC_NOR = 3'b100,
    FUNC_SLL = 3'b101,
    FUNC_SRL = 3'b110,
    FUNC_SRA = 3'b111
  } alu_func_t;

  // Everything the decoder tells the rest of the core for one instruction
  typedef struct packed {
    logic [3:0]  p0_addr;
    logic [3:0]  p1_addr;
    logic [3:0]  dst_addr;
    logic        re0;
    logic        re1;
    logic        we;
    alu_func_t   func;
    logic [3:0]  shamt;
    logic        src1_imm;
    logic [15:0] imm;
    logic        set_flags;
    logic        mem_rd;
    logic        mem_wr;
    logic        link;
    logic        jump_reg;
    logic        branch_taken;
    logic [15:0] branch_off;
    logic        hlt;
  } ctrl_t;

endpackage

// ==== rtl/instr_decode.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module instr_decode (
  input  cpu_pkg::instr_t instr,
  input  cpu_pkg::flags_t flags,
  output cpu_pkg::ctrl_t  ctrl
);

  import cpu_pkg::*;

  logic cond_met;

  // Branch condition check against the flags left by the last ALU operation
  always_comb begin
    case (instr.b_fmt.cond)
      `COND_NEQ:    cond_met = !flags.zr;
      `COND_EQ:     cond_met = flags.zr;
      `COND_GT:     cond_met = !(flags.zr || flags.ne);
      `COND_LT:     cond_met = flags.ne;
      // zr can be set by a logic op while ne still holds an older sign
      `COND_GTE:    cond_met = flags.zr || !flags.ne;
      `COND_LTE:    cond_met = flags.ne || flags.zr;
      `COND_OVFL:   cond_met = flags.ov;
      // Only this code branches unconditionally
      `COND_UNCOND: cond_met = 1'b1;
      default:      cond_met = 1'b0;
    endcase
  end

  always_comb begin
    // Start from a no-op so every enable is off unless an opcode asks for it
    ctrl          = '0;
    ctrl.p0_addr  = instr.r_fmt.rs;
    ctrl.p1_addr  = instr.r_fmt.rt;
    ctrl.dst_addr = instr.r_fmt.rd;
    ctrl.func     = FUNC_ADD;
    ctrl.shamt    = instr.r_fmt.rt;

    case (instr.r_fmt.opcode)
      `OP_ADD, `OP_SUB, `OP_AND, `OP_NOR: begin
        // Opcode bits 14:12 already match the function encoding
        ctrl.func      = alu_func_t'(instr.r_fmt.opcode[2:0]);
        ctrl.re0       = 1'b1;
        ctrl.re1       = 1'b1;
        ctrl.we        = 1'b1;
        ctrl.set_flags = 1'b1;
      end
      `OP_ADDZ: begin
        // Runs as a plain ADD, but the result lands in R0 unless zr is set
        ctrl.func      = FUNC_ADD;
        ctrl.re0       = 1'b1;
        ctrl.re1       = 1'b1;
        ctrl.we        = 1'b1;
        ctrl.dst_addr  = flags.zr ? instr.r_fmt.rd : 4'd0;
        // A dropped ADDZ leaves the flags alone as well
        ctrl.set_flags = flags.zr;
      end
      `OP_SLL, `OP_SRL, `OP_SRA: begin
        // The shifter works on the second operand, so rs goes out on port 1
        ctrl.func      = alu_func_t'(instr.r_fmt.opcode[2:0]);
        ctrl.p1_addr   = instr.r_fmt.rs;
        ctrl.re1       = 1'b1;
        ctrl.we        = 1'b1;
        ctrl.set_flags = 1'b1;
      end
      `OP_LW: begin
        // Base in rs plus sign-extended 4-bit offset, data into the rd field
        ctrl.re0      = 1'b1;
        ctrl.we       = 1'b1;
        ctrl.src1_imm = 1'b1;
        ctrl.imm      = {{12{instr.r_fmt.rt[3]}}, instr.r_fmt.rt};
        ctrl.mem_rd   = 1'b1;
      end
      `OP_SW: begin
        // Store data comes from the register named in bits 11:8
        ctrl.p1_addr  = instr.r_fmt.rd;
        ctrl.re0      = 1'b1;
        ctrl.re1      = 1'b1;
        ctrl.src1_imm = 1'b1;
        ctrl.imm      = {{12{instr.r_fmt.rt[3]}}, instr.r_fmt.rt};
        ctrl.mem_wr   = 1'b1;
      end
      `OP_LHB: begin
        // Reads the destination itself so its low byte survives
        ctrl.func     = FUNC_LHB;
        ctrl.p0_addr  = instr.i_fmt.rd;
        ctrl.re0      = 1'b1;
        ctrl.we       = 1'b1;
        ctrl.src1_imm = 1'b1;
        ctrl.imm      = {instr.i_fmt.imm8, 8'h00};
      end
      `OP_LLB: begin
        // Byte placed high, then shifted back down arithmetically by 8
        ctrl.func     = FUNC_SRA;
        ctrl.shamt    = 4'd8;
        ctrl.we       = 1'b1;
        ctrl.src1_imm = 1'b1;
        ctrl.imm      = {instr.i_fmt.imm8, 8'h00};
      end
      `OP_B: begin
        ctrl.branch_taken = cond_met;
        ctrl.branch_off   = {{7{instr.b_fmt.imm9[8]}}, instr.b_fmt.imm9};
      end
      `OP_JAL: begin
        // Return address goes to the link register, offset spans bits 11:0
        ctrl.link         = 1'b1;
        ctrl.branch_taken = 1'b1;
        ctrl.branch_off   = {{4{instr.i_fmt.rd[3]}}, instr.i_fmt.rd, instr.i_fmt.imm8};
        ctrl.dst_addr     = `LINK_REG;
        ctrl.we           = 1'b1;
      end
      `OP_JR: begin
        ctrl.re0      = 1'b1;
        ctrl.jump_reg = 1'b1;
      end
      `OP_HLT: begin
        // Nothing is enabled, only the halt request goes out
        ctrl.hlt = 1'b1;
      end
      default: begin
        ctrl.hlt = 1'b0;
      end
    endcase
  end

endmodule

// ==== rtl/fetch_pc.sv ====
`timescale 1ns/1ps

module fetch_pc (
  input  logic           clk,
  input  logic           arst_n,
  input  cpu_pkg::ctrl_t ctrl,
  input  logic [15:0]    jr_target,
  output logic [15:0]    pc,
  output logic [15:0]    pc_next_seq,
  output logic           halted
);

  import cpu_pkg::*;

  logic [15:0] branch_target;
  logic [15:0] pc_next;

  // Sequential address doubles as the JAL return value
  assign pc_next_seq = pc + 16'd1;

  // Branch and JAL offsets count from the following instruction
  assign branch_target = pc_next_seq + ctrl.branch_off;

  always_comb begin
    if (halted || ctrl.hlt) begin
      // Stay on the HLT word so the fetch address stops moving
      pc_next = pc;
    end else if (ctrl.jump_reg) begin
      pc_next = jr_target;
    end else if (ctrl.branch_taken) begin
      pc_next = branch_target;
    end else begin
      pc_next = pc_next_seq;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= 16'd0;
    end else begin
      pc <= pc_next;
    end
  end

  // Halted is sticky, only reset brings the core back
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      halted <= 1'b0;
    end else if (ctrl.hlt) begin
      halted <= 1'b1;
    end
  end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  logic           clk,
  input  logic           arst_n,
  input  cpu_pkg::ctrl_t ctrl,
  input  logic [15:0]    src0,
  input  logic [15:0]    src1,
  output logic [15:0]    result,
  output cpu_pkg::flags_t flags
);

  import cpu_pkg::*;

  logic [15:0] op_b;
  logic [15:0] sum;
  logic [15:0] diff;
  logic        sum_ov;
  logic        diff_ov;
  logic        ov_now;
  logic        arith;

  // Second operand is either port 1 or the extended immediate
  assign op_b = ctrl.src1_imm ? ctrl.imm : src1;

  assign sum  = src0 + op_b;
  assign diff = src0 - op_b;

  // Signed overflow shows up as a sign flip that the operands cannot explain
  assign sum_ov  = (src0[15] == op_b[15]) && (sum[15] != src0[15]);
  assign diff_ov = (src0[15] != op_b[15]) && (diff[15] != src0[15]);

  // Only add and subtract touch ne and ov
  assign arith = (ctrl.func == FUNC_ADD) || (ctrl.func == FUNC_SUB);

  always_comb begin
    ov_now = 1'b0;
    case (ctrl.func)
      FUNC_ADD: begin
        // Clamp to the largest magnitude of the first operand's sign
        ov_now = sum_ov;
        result = sum_ov ? (src0[15] ? 16'h8000 : 16'h7fff) : sum;
      end
      FUNC_SUB: begin
        ov_now = diff_ov;
        result = diff_ov ? (src0[15] ? 16'h8000 : 16'h7fff) : diff;
      end
      FUNC_AND: result = src0 & op_b;
      FUNC_NOR: result = ~(src0 | op_b);
      // Shifts act on the second operand, which also serves LLB
      FUNC_SLL: result = op_b << ctrl.shamt;
      FUNC_SRL: result = op_b >> ctrl.shamt;
      FUNC_SRA: result = $signed(op_b) >>> ctrl.shamt;
      // New high byte from the immediate, low byte kept from the register
      FUNC_LHB: result = {op_b[15:8], src0[7:0]};
      default:  result = sum;
    endcase
  end

  // Flags follow the result that is being written this cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flags <= '0;
    end else if (ctrl.set_flags) begin
      flags.zr <= (result == 16'd0);
      if (arith) begin
        // A saturated result still carries the true sign
        flags.ne <= result[15];
        flags.ov <= ov_now;
      end
    end
  end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reg_file (
  input  logic           clk,
  input  logic           arst_n,
  input  cpu_pkg::ctrl_t ctrl,
  input  logic [15:0]    wdata,
  output logic [15:0]    rdata0,
  output logic [15:0]    rdata1
);

  import cpu_pkg::*;

  logic [15:0] regs [`NUM_REGS];

  // Reads are combinational, and R0 or a disabled port gives zero
  assign rdata0 = (ctrl.re0 && (ctrl.p0_addr != 4'd0)) ? regs[ctrl.p0_addr] : 16'd0;
  assign rdata1 = (ctrl.re1 && (ctrl.p1_addr != 4'd0)) ? regs[ctrl.p1_addr] : 16'd0;

  // One write per clock
  // On JAL the decoder points dst_addr at the link register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= 16'd0;
      end
    end else if (ctrl.we && (ctrl.dst_addr != 4'd0)) begin
      // R0 never takes a write, so it stays at zero
      regs[ctrl.dst_addr] <= wdata;
    end
  end

endmodule

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
  input  logic            clk,
  input  logic            arst_n,
  output logic [15:0]     instr_addr,
  input  cpu_pkg::instr_t instr,
  output logic [15:0]     mem_addr,
  output logic [15:0]     mem_wdata,
  output logic            mem_we,
  input  logic [15:0]     mem_rdata,
  output logic            halted
);

  import cpu_pkg::*;

  ctrl_t       dec_ctrl;
  ctrl_t       exe_ctrl;
  flags_t      flags;
  logic [15:0] pc;
  logic [15:0] pc_next_seq;
  logic [15:0] rdata0;
  logic [15:0] rdata1;
  logic [15:0] alu_result;
  logic [15:0] wb_lw;
  logic [15:0] wb_jal;
  logic [15:0] wb_alu;
  logic [15:0] wb_data;

  instr_decode u_instr_decode (
    .instr (instr),
    .flags (flags),
    .ctrl  (dec_ctrl)
  );

  // Once halted, every state change except the held PC is blocked
  always_comb begin
    exe_ctrl = dec_ctrl;
    if (halted) begin
      exe_ctrl.we           = 1'b0;
      exe_ctrl.mem_wr       = 1'b0;
      exe_ctrl.set_flags    = 1'b0;
      exe_ctrl.branch_taken = 1'b0;
      exe_ctrl.jump_reg     = 1'b0;
      exe_ctrl.hlt          = 1'b1;
    end
  end

  // JR takes its target straight from read port 0
  fetch_pc u_fetch_pc (
    .clk         (clk),
    .arst_n      (arst_n),
    .ctrl        (exe_ctrl),
    .jr_target   (rdata0),
    .pc          (pc),
    .pc_next_seq (pc_next_seq),
    .halted      (halted)
  );

  alu u_alu (
    .clk    (clk),
    .arst_n (arst_n),
    .ctrl   (exe_ctrl),
    .src0   (rdata0),
    .src1   (rdata1),
    .result (alu_result),
    .flags  (flags)
  );

  reg_file u_reg_file (
    .clk    (clk),
    .arst_n (arst_n),
    .ctrl   (exe_ctrl),
    .wdata  (wb_data),
    .rdata0 (rdata0),
    .rdata1 (rdata1)
  );

  assign instr_addr = pc;

  // Data port, the address is the base plus offset sum from the ALU
  assign mem_addr  = alu_result;
  assign mem_wdata = rdata1;
  assign mem_we    = exe_ctrl.mem_wr;

  // Write-back candidates
  assign wb_lw  = mem_rdata;
  assign wb_jal = pc_next_seq;
  assign wb_alu = alu_result;

  // load data wins, then the JAL return address
  assign wb_data = exe_ctrl.mem_rd ? wb_lw :
                   exe_ctrl.link   ? wb_jal : wb_alu;

endmodule

// ==== verification/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb;

  import cpu_pkg::*;

  localparam int MEM_WORDS   = 256;
  localparam int TAIL_CYCLES = 3;

  logic        clk;
  logic        arst_n;
  logic [15:0] instr_addr;
  instr_t      instr;
  logic [15:0] mem_addr;
  logic [15:0] mem_wdata;
  logic        mem_we;
  logic [15:0] mem_rdata;
  logic        halted;

  // Instruction and data memories, indexed by the low address byte
  logic [15:0] imem [MEM_WORDS];
  logic [15:0] dmem [MEM_WORDS];

  // All parsed cases back to back, with a start and a length per case
  int          budget_q[$];
  int          prog_start_q[$];
  int          prog_len_q[$];
  int          store_start_q[$];
  int          store_len_q[$];
  logic [15:0] prog_q[$];
  logic [15:0] store_addr_q[$];
  logic [15:0] store_data_q[$];

  // Stores the running case still owes, oldest first
  logic [15:0] exp_addr_q[$];
  logic [15:0] exp_data_q[$];

  int   cycle_count;
  int   cycle_limit;
  logic hlt_pending;

  cpu_top u_cpu_top (
    .clk        (clk),
    .arst_n     (arst_n),
    .instr_addr (instr_addr),
    .instr      (instr),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_we     (mem_we),
    .mem_rdata  (mem_rdata),
    .halted     (halted)
  );

  always #10 clk = ~clk;

  // Both memories answer in the same cycle
  assign instr     = imem[instr_addr[7:0]];
  assign mem_rdata = dmem[mem_addr[7:0]];

  task automatic stop_failed();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  task automatic abort_run(input string reason);
    $display("%s at %0t", reason, $time);
    stop_failed();
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s expected %h, actual %h", $time, name, expected, actual);
      stop_failed();
    end
  endtask

  // Reads every case up front so the timeout limit is known before the first edge
  task automatic load_case_file();
    int               fd;
    int               code;
    int               count;
    int               value;
    logic [15:0]      word;
    logic [15:0]      addr;
    logic [15:0]      data;
    logic [63:0]      tag;
    logic [8*160-1:0] rest;
    fd = $fopen("verification/cpu_cases.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open verification/cpu_cases.txt");
    end
    cycle_limit = 0;
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag == "#") begin
        code = $fgets(rest, fd);
      end else if (tag == "C") begin
        code = $fscanf(fd, "%d", value);
        budget_q.push_back(value);
        prog_start_q.push_back(prog_q.size());
        store_start_q.push_back(store_addr_q.size());
        // Each case costs its budget plus two cycles in reset
        cycle_limit += value + 2;
      end else if (tag == "I") begin
        code = $fscanf(fd, "%d", count);
        for (int i = 0; i < count; i++) begin
          code = $fscanf(fd, "%h", word);
          if (code != 1) begin
            abort_run("Bad instruction word in the case file");
          end
          prog_q.push_back(word);
        end
      end else if (tag == "S") begin
        code = $fscanf(fd, "%h %h", addr, data);
        if (code != 2) begin
          abort_run("Bad store line in the case file");
        end
        store_addr_q.push_back(addr);
        store_data_q.push_back(data);
      end else if (tag == "E") begin
        prog_len_q.push_back(prog_q.size() - prog_start_q[$]);
        store_len_q.push_back(store_addr_q.size() - store_start_q[$]);
      end else begin
        abort_run("Unknown line tag in the case file");
      end
    end
    $fclose(fd);
    if (budget_q.size() == 0 || prog_len_q.size() != budget_q.size()) begin
      abort_run("The case file holds no complete case");
    end
  endtask

  // Loads one case while reset is low, then runs it up to and past HLT
  task automatic run_case(input int idx);
    logic [15:0] held_pc;
    // Unused words decode as HLT, unused data carries its own address
    for (int a = 0; a < MEM_WORDS; a++) begin
      imem[a] = {`OP_HLT, 4'h0, a[7:0]};
      dmem[a] = {a[7:0], ~a[7:0]};
    end
    for (int i = 0; i < prog_len_q[idx]; i++) begin
      imem[i] = prog_q[prog_start_q[idx] + i];
    end
    exp_addr_q.delete();
    exp_data_q.delete();
    for (int i = 0; i < store_len_q[idx]; i++) begin
      exp_addr_q.push_back(store_addr_q[store_start_q[idx] + i]);
      exp_data_q.push_back(store_data_q[store_start_q[idx] + i]);
    end
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    while (!halted) begin
      @(posedge clk);
    end
    // The fetch address must freeze on the HLT word
    held_pc = instr_addr;
    repeat (TAIL_CYCLES) begin
      @(posedge clk);
      check_value("instr_addr", held_pc, instr_addr);
      check_value("halted", 16'd1, {15'd0, halted});
    end
    if (exp_addr_q.size() != 0) begin
      abort_run("The core halted with expected stores still missing");
    end
    arst_n <= 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      abort_run("Timeout because the cases ran past their cycle budgets");
    end
  end

  // Store checker and data memory write, using values from just before the edge
  always @(posedge clk) begin
    if (arst_n) begin
      // HLT fetched one edge ago must have raised halted by now
      if (hlt_pending) begin
        check_value("halted", 16'd1, {15'd0, halted});
      end
      hlt_pending = !halted && (instr.r_fmt.opcode == `OP_HLT);
      if (mem_we) begin
        if (exp_addr_q.size() == 0) begin
          abort_run("A store happened after the last expected store");
        end
        check_value("mem_addr", exp_addr_q[0], mem_addr);
        check_value("mem_wdata", exp_data_q[0], mem_wdata);
        void'(exp_addr_q.pop_front());
        void'(exp_data_q.pop_front());
        dmem[mem_addr[7:0]] <= mem_wdata;
      end
    end else begin
      hlt_pending = 1'b0;
    end
  end

  initial begin
    clk         = 1'b0;
    arst_n      = 1'b0;
    cycle_count = 0;
    hlt_pending = 1'b0;
    load_case_file();
    for (int c = 0; c < budget_q.size(); c++) begin
      run_case(c);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== verification/cpu_cases.txt ====
# Tags are C budget, I count then hex words from address 0, S hex addr and hex data, E end
# S lines give the expected stores in the order the program makes them
# ALU results on LLB and LHB operands with saturation and shifts
C 40
I 25
B105 B203 0312 9300 2412 9401 3512 9502 4612 9603 5714 9704 B8FF
A87F 0981 9905 BA00 AA80 7BA3 9B06 6CA3 9C07 2DA1 9D13 F000
S 0000 0008
S 0001 0002
S 0002 0001
S 0003 FFF8
S 0004 0050
S 0005 7FFF
S 0006 F000
S 0007 1000
S 0008 8000
E
# ADDZ taken then dropped, LW after SW, writes to R0 lost
C 30
I 18
B107 B207 2312 B410 B520 1645 9600 B755 1745 9701 942E 881E 9802
0045 9003 8005 9004 F000
S 0000 0030
S 0001 0055
S 0005 0010
S 0002 0010
S 0003 0000
S 0004 0000
E
# Each branch condition either skips or keeps one store
C 36
I 27
B101 B202 B999 B4FF A47F 2311 C001 9900 C201 9901 2321 C401 9902 C601
9903 2312 C801 9904 CA01 9905 0341 CC01 9906 CE01 9907 9117 F000
S 0000 FF99
S 0003 FF99
S 0004 FF99
S 0008 0001
E
# JAL links into R15 and JR returns through it
C 20
I 7
B101 D003 9F00 F000 9101 9F01 E0F0
S 0001 0002
S 0000 0002
E
# Nothing is stored after HLT
C 15
I 5
B105 9100 F000 9101 9102
S 0000 0005
E

// ==== sim.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/instr_decode.sv
rtl/fetch_pc.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/cpu_top.sv
verification/cpu_tb.sv
